// File: design/mxv_defines.svh
`ifndef MXV_DEFINES_SVH
`define MXV_DEFINES_SVH

// Element width of one matrix or vector entry
`define MXV_DATA_W 8

// Row sum width, wide enough for 8 products of 8x8 bits
`define MXV_ACC_W 20

`define MXV_NMAX 8 // Largest dimension the controller accepts

`define MXV_OP_DEPTH 64 // NMAX squared operand pairs
`define MXV_RES_DEPTH 8 // One result word per row

`endif

// File: design/mxv_pkg.sv
`include "mxv_defines.svh"

package mxv_pkg;

	// Controller states, in the order a row is processed
	typedef enum logic [2:0]
	{
		IDLE,
		LOAD,
		OP,
		RESULT,
		POP_RES,
		TRANSMIT
	} state_e;

	typedef logic [3:0] dim_t; // Matrix dimension, 1 to 8
	typedef logic [3:0] cnt_t; // Row or column position

	typedef logic [`MXV_DATA_W-1:0] elem_t;
	typedef logic [`MXV_ACC_W-1:0]  acc_t;

endpackage

// File: design/mxv_config.sv
`timescale 1ns/1ps
`include "mxv_defines.svh"

module mxv_config import mxv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic cfg_we,
	input  dim_t cfg_n,
	input  logic busy,
	output dim_t n
);

	logic cfg_legal;

	// Only 1 to NMAX is a usable dimension
	assign cfg_legal = (cfg_n != '0) && (cfg_n <= dim_t'(`MXV_NMAX));

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			n <= dim_t'(1); // Smallest legal matrix until the host says otherwise
		end
		else if (cfg_we && !busy && cfg_legal)
		begin
			n <= cfg_n;
		end
	end

	// The FSM compares its counters against n every cycle of a run, so the
	// lock on busy keeps a half-finished matrix from changing shape

endmodule

// File: design/mxv_fifo.sv
`timescale 1ns/1ps

module mxv_fifo
#(
	parameter int WIDTH = 16,
	parameter int DEPTH = 64
)
(
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata,
	output logic             full,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             push_ok;
	logic             pop_ok;

	assign push_ok = push && !full;  // Writes into a full buffer are lost
	assign pop_ok  = pop && !empty;

	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign rdata = mem[rd_ptr]; // Head is visible without a pop

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			// Simultaneous push and pop leave the occupancy alone
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

endmodule

// File: design/mxv_control.sv
`timescale 1ns/1ps

module mxv_control import mxv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  dim_t n,
	input  logic op_empty,
	output logic op_pop,
	output logic mac_en,
	output logic mac_clr,
	output logic res_push,
	output logic res_pop,
	output logic out_valid,
	output logic busy,
	output logic done
);

	state_e state;

	cnt_t col_cnt; // Pairs popped in this row, then results drained
	cnt_t row_cnt; // Rows already pushed into the result FIFO

	logic col_inc;
	logic col_clr;
	logic row_inc;
	logic row_clr;
	logic col_ovf;
	logic row_last;

	// **********************************************************************
	// State sequencing
	// **********************************************************************

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
						state <= LOAD;
				end

				LOAD:
				begin
					if (!op_empty) // Stall here until the host catches up
						state <= OP;
				end

				OP:
				begin
					if (col_ovf)
						state <= RESULT;
					else
						state <= LOAD;
				end

				RESULT:
				begin
					if (row_last)
						state <= POP_RES; // Whole matrix done, start draining
					else
						state <= LOAD;
				end

				POP_RES:
				begin
					state <= TRANSMIT;
				end

				TRANSMIT:
				begin
					if (col_ovf)
						state <= IDLE;
					else
						state <= POP_RES;
				end

				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// **********************************************************************
	// Output and counter control decode
	// **********************************************************************

	always_comb
	begin
		op_pop    = 1'b0;
		mac_en    = 1'b0;
		mac_clr   = 1'b0;
		res_push  = 1'b0;
		res_pop   = 1'b0;
		out_valid = 1'b0;
		done      = 1'b0;
		col_inc   = 1'b0;
		col_clr   = 1'b0;
		row_inc   = 1'b0;
		row_clr   = 1'b0;
		busy      = (state != IDLE);

		case (state)
			IDLE:
			begin
				col_clr = 1'b1;
				row_clr = 1'b1;
			end

			LOAD:
			begin
				op_pop  = !op_empty;
				col_inc = !op_empty; // Count only pairs actually taken
			end

			OP:
			begin
				mac_en = 1'b1;
			end

			RESULT:
			begin
				res_push = 1'b1;
				mac_clr  = 1'b1; // Acc is sampled by the push on this same edge
				row_inc  = 1'b1;
				col_clr  = 1'b1;
			end

			POP_RES:
			begin
				res_pop = 1'b1;
				col_inc = 1'b1;
			end

			TRANSMIT:
			begin
				out_valid = 1'b1;
				done      = col_ovf;
			end

			default:
			begin
				col_clr = 1'b1;
				row_clr = 1'b1;
			end
		endcase
	end

	// **********************************************************************
	// Counters
	// **********************************************************************

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			col_cnt <= '0;
		else if (col_clr)
			col_cnt <= '0;
		else if (col_inc)
			col_cnt <= col_cnt + 1'b1;
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			row_cnt <= '0;
		else if (row_clr)
			row_cnt <= '0;
		else if (row_inc)
			row_cnt <= row_cnt + 1'b1;
	end

	assign col_ovf = (col_cnt == cnt_t'(n));

	// Checked in RESULT before the increment, so the last row is n-1
	assign row_last = (row_cnt == cnt_t'(n - 1'b1));

endmodule

// File: design/mxv_mac.sv
`timescale 1ns/1ps

module mxv_mac import mxv_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  en,
	input  logic  clr,
	input  elem_t a,
	input  elem_t b,
	output acc_t  acc
);

	elem_t a_q;
	elem_t b_q;
	acc_t  product;

	// The operand head is sampled every cycle. The edge that ends LOAD
	// captures the popped pair, which then holds steady through OP
	always_ff @(posedge clk)
	begin
		a_q <= a;
		b_q <= b;
	end

	assign product = acc_t'(a_q) * acc_t'(b_q);

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			acc <= '0;
		end
		else if (clr)
		begin
			acc <= '0; // Start of a fresh row
		end
		else if (en)
		begin
			acc <= acc + product; // Feed the running sum back in
		end
	end

endmodule

// File: design/mxv_core.sv
`timescale 1ns/1ps
`include "mxv_defines.svh"

module mxv_core import mxv_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      op_wr,
	input  logic [2*`MXV_DATA_W-1:0] op_data,
	output logic                      op_full,
	input  logic                      cfg_we,
	input  dim_t                      cfg_n,
	input  logic                      start,
	output logic                      out_valid,
	output acc_t                      out_data,
	output logic                      busy,
	output logic                      done
);

	dim_t                      n;
	logic [2*`MXV_DATA_W-1:0] op_rdata;
	logic                      op_empty;
	logic                      op_pop;
	elem_t                     op_a;
	elem_t                     op_b;
	logic                      mac_en;
	logic                      mac_clr;
	acc_t                      acc;
	logic                      res_push;
	logic                      res_pop;
	acc_t                      res_rdata;

	assign op_a = op_rdata[2*`MXV_DATA_W-1:`MXV_DATA_W]; // Matrix element
	assign op_b = op_rdata[`MXV_DATA_W-1:0];             // Vector element

	mxv_config u_config
	(
		.clk    (clk),
		.rst    (rst),
		.cfg_we (cfg_we),
		.cfg_n  (cfg_n),
		.busy   (busy),
		.n      (n)
	);

	mxv_fifo #(.WIDTH(2*`MXV_DATA_W), .DEPTH(`MXV_OP_DEPTH)) u_op_fifo
	(
		.clk   (clk),
		.rst   (rst),
		.push  (op_wr),
		.pop   (op_pop),
		.wdata (op_data),
		.rdata (op_rdata),
		.full  (op_full),
		.empty (op_empty)
	);

	mxv_control u_control
	(
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.n         (n),
		.op_empty  (op_empty),
		.op_pop    (op_pop),
		.mac_en    (mac_en),
		.mac_clr   (mac_clr),
		.res_push  (res_push),
		.res_pop   (res_pop),
		.out_valid (out_valid),
		.busy      (busy),
		.done      (done)
	);

	mxv_mac u_mac
	(
		.clk (clk),
		.rst (rst),
		.en  (mac_en),
		.clr (mac_clr),
		.a   (op_a),
		.b   (op_b),
		.acc (acc)
	);

	// Never overruns, the controller pushes at most NMAX rows per run
	mxv_fifo #(.WIDTH(`MXV_ACC_W), .DEPTH(`MXV_RES_DEPTH)) u_res_fifo
	(
		.clk   (clk),
		.rst   (rst),
		.push  (res_push),
		.pop   (res_pop),
		.wdata (acc),
		.rdata (res_rdata),
		.full  (),
		.empty ()
	);

	// Head is captured on the pop so it is stable while out_valid is high
	always_ff @(posedge clk)
	begin
		if (res_pop)
			out_data <= res_rdata;
	end

endmodule

// File: verif/mxv_clk_gen.sv
`timescale 1ns/1ps

module mxv_clk_gen
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk; // 10 ns period
	end

	initial
	begin
		rst = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst = 1'b1; // Release just after an edge, away from the flops
	end

endmodule

// File: verif/mxv_tb.sv
`timescale 1ns/1ps
`include "mxv_defines.svh"

module mxv_tb
	import mxv_pkg::*;
();

	logic                     clk;
	logic                     rst;
	logic                     op_wr;
	logic [2*`MXV_DATA_W-1:0] op_data;
	logic                     op_full;
	logic                     cfg_we;
	dim_t                     cfg_n;
	logic                     start;
	logic                     out_valid;
	acc_t                     out_data;
	logic                     busy;
	logic                     done;

	integer seed;
	int     done_count = 0;
	int     results_at_done = 0; // Strobes seen up to and including done
	acc_t   got[$];
	acc_t   expected[$];
	logic [15:0] pairs[$];     // Matrix element high byte, vector element low byte

	mxv_clk_gen u_clk_gen (.clk(clk), .rst(rst));

	mxv_core UUT
	(
		.clk(clk), .rst(rst), .op_wr(op_wr), .op_data(op_data), .op_full(op_full),
		.cfg_we(cfg_we), .cfg_n(cfg_n), .start(start), .out_valid(out_valid),
		.out_data(out_data), .busy(busy), .done(done)
	);

	// Outputs are collected mid-cycle, well clear of both edges
	always @(negedge clk)
	begin
		if (out_valid)
			got.push_back(out_data);
		if (done)
		begin
			done_count = done_count + 1;
			results_at_done = got.size();
		end
	end

	// **********************************************************************
	// Helpers
	// **********************************************************************

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected_val);
		if (actual !== expected_val)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected_val);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst !== 1'b1)
		begin
			step();
			cycles++;
			if (cycles > 50)
				report_timeout("reset release");
		end
	endtask

	task automatic wait_done(input int target, input int limit);
		int     cycles;
		state_e st;
		cycles = 0;
		while (done_count < target)
		begin
			step();
			cycles++;
			if (cycles > limit)
			begin
				st = UUT.u_control.state;
				report_timeout($sformatf("done, controller in state %s", st.name()));
			end
		end
	endtask

	task automatic write_op(input logic [15:0] data);
		op_data = data;
		op_wr   = 1'b1;
		step();
		op_wr   = 1'b0;
	endtask

	task automatic configure(input dim_t value);
		cfg_n  = value;
		cfg_we = 1'b1;
		step();
		cfg_we = 1'b0;
	endtask

	task automatic start_run();
		start = 1'b1;
		step();
		start = 1'b0;
	endtask

	function automatic int random_dim();
		int r;
		r = $random(seed);
		return (r & 7) + 1;
	endfunction

	task automatic make_pairs(input int count);
		int r;
		pairs.delete();
		for (int k = 0; k < count; k++)
		begin
			r = $random(seed);
			pairs.push_back(r[15:0]);
		end
	endtask

	// Row i sums a[i][j]*b[i][j] over the pairs of that row, in write order
	task automatic build_expected(input int n);
		int unsigned sum;
		int unsigned a;
		int unsigned b;
		expected.delete();
		for (int i = 0; i < n; i++)
		begin
			sum = 0;
			for (int j = 0; j < n; j++)
			begin
				a = pairs[i*n + j][15:8];
				b = pairs[i*n + j][7:0];
				sum = sum + a * b;
			end
			expected.push_back(acc_t'(sum));
		end
	endtask

	task automatic write_pairs(input int max_gap);
		int gap;
		foreach (pairs[k])
		begin
			write_op(pairs[k]);
			if (max_gap > 0)
			begin
				gap = $unsigned($random(seed)) % (max_gap + 1);
				repeat (gap) step();
			end
		end
	endtask

	task automatic check_results(input int n);
		check_value("out_valid count at done", results_at_done, n);
		check_value("out_valid count", got.size(), n);
		for (int i = 0; i < n; i++)
			check_value($sformatf("out_data row %0d", i), got[i], expected[i]);
	endtask

	// Full run on the dimension already configured in the DUT
	task automatic run_matrix(input int n, input bit slow);
		int target;
		make_pairs(n * n);
		build_expected(n);
		got.delete();
		target = done_count + 1;
		if (slow)
		begin
			start_run();
			write_pairs(4); // Controller starves in LOAD between writes
		end
		else
		begin
			write_pairs(0);
			start_run();
		end
		wait_done(target, 2000);
		step();
		check_results(n);
		check_value("busy", busy, 0);
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		int n;
		int target;
		seed    = 32'hf18e_a311;
		op_wr   = 1'b0;
		op_data = '0;
		cfg_we  = 1'b0;
		cfg_n   = '0;
		start   = 1'b0;

		wait_reset_release();
		step();
		check_value("busy", busy, 0);
		check_value("out_valid", out_valid, 0);
		check_value("done", done, 0);
		check_value("op_full", op_full, 0);

		// Illegal sizes and a write while busy must all leave N at 3
		configure(dim_t'(3));
		configure(dim_t'(0));
		configure(dim_t'(9));
		make_pairs(9);
		build_expected(3);
		write_pairs(0);
		got.delete();
		target = done_count + 1;
		start_run();
		check_value("busy", busy, 1);
		configure(dim_t'(5));
		wait_done(target, 2000);
		step();
		check_results(3);
		run_matrix(3, 1'b0);

		repeat (4)
		begin
			n = random_dim();
			configure(dim_t'(n));
			run_matrix(n, 1'b0);
		end

		repeat (3)
		begin
			n = random_dim();
			configure(dim_t'(n));
			run_matrix(n, 1'b1);
		end

		// Overfill the operand FIFO by one so that the last write is lost
		configure(dim_t'(8));
		make_pairs(65);
		for (int k = 0; k < 64; k++)
			write_op(pairs[k]);
		check_value("op_full", op_full, 1);
		write_op(pairs[64]);
		check_value("op_full", op_full, 1);
		void'(pairs.pop_back());
		build_expected(8);
		got.delete();
		target = done_count + 1;
		start_run();
		wait_done(target, 2000);
		step();
		check_results(8);
		check_value("op_full", op_full, 0);

		repeat (5)
		begin
			n = random_dim();
			configure(dim_t'(n));
			run_matrix(n, 1'b0);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

// File: mxv_core.f
+incdir+design
design/mxv_pkg.sv
design/mxv_config.sv
design/mxv_fifo.sv
design/mxv_control.sv
design/mxv_mac.sv
design/mxv_core.sv
verif/mxv_clk_gen.sv
verif/mxv_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the mxv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f mxv_core.f --top-module mxv_tb -o mxv_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mxv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "PASS"
exit 0
